// File: rtl/dot_pkg.sv
package dot_pkg;

    // datapath and lane geometry
    localparam int DATA_WIDTH = 16;
    localparam int NUM_LANES  = 8;
    localparam int LANE_W     = $clog2(NUM_LANES);

    // apb bus widths
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // register byte offsets
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL      = 8'h00;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS    = 8'h04;
    localparam logic [APB_ADDR_W-1:0] ADDR_RESULT    = 8'h08;
    localparam logic [APB_ADDR_W-1:0] ADDR_OPND_BASE = 8'h20;

    // ctrl word: start in bit 0, lane mask in bits 15:8
    typedef struct packed {
        logic [23-NUM_LANES:0] rsvd_hi;
        logic [NUM_LANES-1:0]  mask;
        logic [6:0]            rsvd_lo;
        logic                  start;
    } ctrl_t;

    // operand word: weight high half, activation low half
    typedef struct packed {
        logic [DATA_WIDTH-1:0] weight;
        logic [DATA_WIDTH-1:0] act;
    } opnd_pair_t;

    // one write word, read as ctrl or as operand pair by address
    typedef union packed {
        ctrl_t      ctrl;
        opnd_pair_t pair;
    } apb_word_u;

    typedef struct packed {
        logic                                 token;
        logic [NUM_LANES-1:0]                 mask;
        logic [NUM_LANES-1:0][DATA_WIDTH-1:0] weight;
        logic [NUM_LANES-1:0][DATA_WIDTH-1:0] act;
    } operand_vec_t;

    typedef struct packed {
        logic                                 token;
        logic [NUM_LANES-1:0]                 mask;
        logic [NUM_LANES-1:0][DATA_WIDTH-1:0] prod;
    } product_vec_t;

    typedef struct packed {
        logic                  token;
        logic                  any_valid;
        logic [DATA_WIDTH-1:0] sum;
    } tree_out_t;

endpackage

// File: rtl/apb_regs.sv
`timescale 1ns/10ps

module apb_regs (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [dot_pkg::APB_ADDR_W-1:0] i_paddr,
    input  logic [dot_pkg::APB_DATA_W-1:0] i_pwdata,
    input  logic [dot_pkg::DATA_WIDTH-1:0] i_result,
    input  logic                           i_done,
    input  logic                           i_empty,
    output logic [dot_pkg::APB_DATA_W-1:0] o_prdata,
    output logic                           o_pready,
    output logic                           o_pslverr,
    output logic                           o_clear_done,
    output dot_pkg::operand_vec_t          o_opnd
);
    import dot_pkg::*;

    apb_word_u                            wdata;
    apb_word_u                            rdata;
    logic                                 access;
    logic                                 wr_access;
    logic                                 rd_access;
    logic                                 sel_ctrl;
    logic                                 sel_status;
    logic                                 sel_result;
    logic                                 sel_opnd;
    logic                                 start_wr;
    logic [APB_ADDR_W-1:0]                opnd_off;
    logic [LANE_W-1:0]                    opnd_idx;
    logic [NUM_LANES-1:0]                 mask_q;
    logic [NUM_LANES-1:0][DATA_WIDTH-1:0] weight_q;
    logic [NUM_LANES-1:0][DATA_WIDTH-1:0] act_q;

    // access phase of a transfer, no wait states
    assign access    = i_psel && i_penable;
    assign wr_access = access && i_pwrite;
    assign rd_access = access && !i_pwrite;
    assign o_pready  = 1'b1;

    // same word seen as ctrl or operand pair
    assign wdata = i_pwdata;

    // address decode
    assign sel_ctrl   = (i_paddr == ADDR_CTRL);
    assign sel_status = (i_paddr == ADDR_STATUS);
    assign sel_result = (i_paddr == ADDR_RESULT);
    assign opnd_off   = i_paddr - ADDR_OPND_BASE;
    assign sel_opnd   = (i_paddr >= ADDR_OPND_BASE)
                     && (opnd_off < APB_ADDR_W'(4 * NUM_LANES))
                     && (i_paddr[1:0] == 2'b00);
    // word index of the operand pair
    assign opnd_idx   = opnd_off[LANE_W+1:2];

    // unmapped address flags an error in the access cycle
    assign o_pslverr = access && !(sel_ctrl || sel_status || sel_result || sel_opnd);

    // any ctrl write drops done
    assign o_clear_done = wr_access && sel_ctrl;
    assign start_wr     = wr_access && sel_ctrl && wdata.ctrl.start;

    // mask and operand storage
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            mask_q   <= '0;
            weight_q <= '0;
            act_q    <= '0;
        end
        else if (wr_access)
        begin
            if (sel_ctrl)
            begin
                mask_q <= wdata.ctrl.mask;
            end
            if (sel_opnd)
            begin
                weight_q[opnd_idx] <= wdata.pair.weight;
                act_q[opnd_idx]    <= wdata.pair.act;
            end
        end
    end

    // one-cycle token per start write
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_opnd.token <= 1'b0;
        end
        else
        begin
            o_opnd.token <= start_wr;
        end
    end

    // snapshot rides with the token, mask taken from the same write
    always_ff @(posedge i_clk)
    begin
        if (start_wr)
        begin
            o_opnd.mask   <= wdata.ctrl.mask;
            o_opnd.weight <= weight_q;
            o_opnd.act    <= act_q;
        end
    end

    // readback mux, zero outside a read access
    always_comb
    begin
        rdata = '0;
        if (rd_access)
        begin
            if (sel_ctrl)
            begin
                rdata.ctrl.mask = mask_q;
            end
            else if (sel_status)
            begin
                rdata = {30'd0, i_empty, i_done};
            end
            else if (sel_result)
            begin
                rdata = APB_DATA_W'(i_result);
            end
            else if (sel_opnd)
            begin
                rdata.pair.weight = weight_q[opnd_idx];
                rdata.pair.act    = act_q[opnd_idx];
            end
        end
    end

    assign o_prdata = rdata;

endmodule

// File: rtl/mult_array.sv
`timescale 1ns/10ps

module mult_array (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  dot_pkg::operand_vec_t i_opnd,
    output dot_pkg::product_vec_t o_prod
);
    import dot_pkg::*;

    // token is the only control state here
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_prod.token <= 1'b0;
        end
        else
        begin
            o_prod.token <= i_opnd.token;
        end
    end

    // lane products, all lanes multiply
    // 16-bit target keeps the low half only, wraps mod 2^16
    always_ff @(posedge i_clk)
    begin
        o_prod.mask <= i_opnd.mask;
        for (int k = 0; k < NUM_LANES; k++)
        begin
            o_prod.prod[k] <= DATA_WIDTH'(i_opnd.weight[k] * i_opnd.act[k]);
        end
    end

endmodule

// File: rtl/adder_tree_comb.sv
`timescale 1ns/10ps

module adder_tree_comb #(
    parameter int N_IN = 8,
    parameter int W    = 16
) (
    input  logic [N_IN-1:0]        i_valid,
    input  logic [N_IN-1:0][W-1:0] i_data,
    input  logic                   i_token,
    output logic [W-1:0]           o_sum,
    output logic                   o_valid,
    output logic                   o_token
);

    // ceiling so that a non power of two count still reaches one root
    localparam int NUM_LEVEL = $clog2(N_IN);

    for (genvar l = 0; l <= NUM_LEVEL; l++)
    begin : g_lvl
        // nodes in this level, ceil(N_IN / 2^l)
        localparam int CNT = (N_IN + (1 << l) - 1) >> l;

        logic [W-1:0] data [CNT];
        logic         vld  [CNT];

        if (l == 0)
        begin : g_leaf
            for (genvar j = 0; j < CNT; j++)
            begin : g_in
                assign data[j] = i_data[j];
                assign vld[j]  = i_valid[j];
            end
        end
        else
        begin : g_add
            // node count of the level feeding this one
            localparam int PREV = (N_IN + (1 << (l - 1)) - 1) >> (l - 1);

            for (genvar j = 0; j < CNT; j++)
            begin : g_node
                logic [W-1:0] a_d;
                logic [W-1:0] b_d;
                logic         a_v;
                logic         b_v;

                assign a_d = g_lvl[l-1].data[2*j];
                assign a_v = g_lvl[l-1].vld[2*j];

                if (2 * j + 1 < PREV)
                begin : g_pair
                    assign b_d = g_lvl[l-1].data[2*j+1];
                    assign b_v = g_lvl[l-1].vld[2*j+1];
                end
                else
                begin : g_pad
                    // odd node, partner is an invalid zero
                    assign b_d = '0;
                    assign b_v = 1'b0;
                end

                // add both, pass the valid one, or invalid zero
                always_comb
                begin
                    case ({b_v, a_v})
                        2'b11:   data[j] = a_d + b_d;
                        2'b01:   data[j] = a_d;
                        2'b10:   data[j] = b_d;
                        default: data[j] = '0;
                    endcase
                    vld[j] = a_v || b_v;
                end
            end
        end
    end

    // root node
    assign o_sum   = g_lvl[NUM_LEVEL].data[0];
    assign o_valid = g_lvl[NUM_LEVEL].vld[0];
    // no state, token passes in the same cycle
    assign o_token = i_token;

endmodule

// File: rtl/result_reg.sv
`timescale 1ns/10ps

module result_reg (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  dot_pkg::tree_out_t             i_tree,
    input  logic                           i_clear_done,
    output logic [dot_pkg::DATA_WIDTH-1:0] o_result,
    output logic                           o_done,
    output logic                           o_empty
);
    import dot_pkg::*;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_result <= '0;
            o_done   <= 1'b0;
            o_empty  <= 1'b0;
        end
        else if (i_tree.token)
        begin
            // empty mask stores zero
            o_result <= i_tree.any_valid ? i_tree.sum : DATA_WIDTH'(0);
            o_done   <= 1'b1;
            o_empty  <= !i_tree.any_valid;
        end
        else if (i_clear_done)
        begin
            // result and empty stay readable
            o_done <= 1'b0;
        end
    end

endmodule

// File: rtl/dot_engine_top.sv
`timescale 1ns/10ps

module dot_engine_top (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [dot_pkg::APB_ADDR_W-1:0] i_paddr,
    input  logic [dot_pkg::APB_DATA_W-1:0] i_pwdata,
    output logic [dot_pkg::APB_DATA_W-1:0] o_prdata,
    output logic                           o_pready,
    output logic                           o_pslverr
);
    import dot_pkg::*;

    operand_vec_t          opnd;
    product_vec_t          prod;
    tree_out_t             tree;
    logic [DATA_WIDTH-1:0] result;
    logic                  done;
    logic                  empty;
    logic                  clear_done;

    // input side, apb slave and operand storage
    apb_regs u_apb_regs (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .i_result     (result),
        .i_done       (done),
        .i_empty      (empty),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_clear_done (clear_done),
        .o_opnd       (opnd)
    );

    // registered products, one cycle after start
    mult_array u_mult_array (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_opnd (opnd),
        .o_prod (prod)
    );

    // masked reduction, lane mask doubles as per-lane valid
    adder_tree_comb #(
        .N_IN (NUM_LANES),
        .W    (DATA_WIDTH)
    ) u_adder_tree_comb (
        .i_valid (prod.mask),
        .i_data  (prod.prod),
        .i_token (prod.token),
        .o_sum   (tree.sum),
        .o_valid (tree.any_valid),
        .o_token (tree.token)
    );

    // output side, sum and flags for readback
    result_reg u_result_reg (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_tree       (tree),
        .i_clear_done (clear_done),
        .o_result     (result),
        .o_done       (done),
        .o_empty      (empty)
    );

endmodule

// File: dv/dot_engine_tb.sv
`timescale 1ns/10ps

module dot_engine_tb;
    import dot_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 6;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // model copy of the operand registers
    logic [DATA_WIDTH-1:0] w_mdl [NUM_LANES];
    logic [DATA_WIDTH-1:0] a_mdl [NUM_LANES];
    logic [31:0]           rng;
    logic [31:0]           rd;
    logic                  err;
    logic [7:0]            mask;
    int                    n_reads;
    // expected and observed results paired by the compare process
    logic [31:0]           exp_q [$];
    logic [31:0]           obs_q [$];
    int                    checks;
    int                    errors;
    int                    test_err;

    dot_engine_top u_dot_engine_top (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // masked sum of 16-bit products mod 2^16
    function automatic logic [DATA_WIDTH-1:0] ref_dot(input logic [7:0] m);
        logic [DATA_WIDTH-1:0] acc;
        logic [31:0]           full;
        acc = '0;
        for (int k = 0; k < NUM_LANES; k++)
        begin
            if (m[k])
            begin
                full = 32'(w_mdl[k]) * 32'(a_mdl[k]);
                acc  = acc + full[DATA_WIDTH-1:0];
            end
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // all bus tasks start and end 1 ns after a rising edge
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic slverr);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        slverr = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic slverr);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // prdata is stable mid access cycle
        @(negedge clk);
        data   = prdata;
        slverr = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_operands(input bit all_ones);
        logic e;
        for (int k = 0; k < NUM_LANES; k++)
        begin
            rng = xorshift32(rng);
            {w_mdl[k], a_mdl[k]} = all_ones ? 32'hffff_ffff : rng;
            apb_write(8'(ADDR_OPND_BASE + 4 * k), {w_mdl[k], a_mdl[k]}, e);
        end
    endtask

    task automatic check_operands();
        logic [31:0] d;
        logic        e;
        for (int k = 0; k < NUM_LANES; k++)
        begin
            apb_read(8'(ADDR_OPND_BASE + 4 * k), d, e);
            check_value($sformatf("OPND%0d", k), d, {w_mdl[k], a_mdl[k]});
        end
    endtask

    // bounded status poll until done rises
    task automatic wait_done(output logic [31:0] status, output int reads);
        logic e;
        int   n;
        n      = 0;
        status = '0;
        while (!status[0] && n < 6)
        begin
            apb_read(ADDR_STATUS, status, e);
            n++;
        end
        reads = n;
        if (!status[0])
        begin
            errors++;
            $display("done flag did not rise within %0d status reads", n);
        end
    endtask

    // hold the sequence until the compare process has drained
    task automatic drain_compare();
        while (obs_q.size() != 0)
            @(posedge clk);
        #1;
    endtask

    task automatic run_dot(input logic [7:0] m);
        logic [31:0] st;
        logic [31:0] res;
        logic        e;
        int          reads;
        apb_write(ADDR_CTRL, {16'h0, m, 8'h01}, e);
        exp_q.push_back(32'(ref_dot(m)));
        wait_done(st, reads);
        // done shows up on the second read after the fixed latency
        check_value("STATUS reads", 32'(reads), 32'd2);
        check_value("STATUS", st, {30'd0, m == 8'h00, 1'b1});
        apb_read(ADDR_RESULT, res, e);
        obs_q.push_back(res);
        drain_compare();
    endtask

    task automatic end_test(input string name);
        if (errors == test_err)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    // result comparison against the reference queue
    always @(posedge clk)
    begin
        if (obs_q.size() != 0 && exp_q.size() != 0)
            check_value("RESULT", obs_q.pop_front(), exp_q.pop_front());
    end

    // watchdog sized from the test count
    initial
    begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog timeout, run did not finish in %0d cycles", NUM_TESTS * 200);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        rng      = 32'hf82dc477;
        checks   = 0;
        errors   = 0;
        test_err = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset values then register readback
        apb_read(ADDR_CTRL, rd, err);
        check_value("CTRL", rd, 32'h0);
        check_value("PSLVERR", 32'(err), 32'h0);
        check_value("PREADY", 32'(pready), 32'h1);
        apb_read(ADDR_STATUS, rd, err);
        check_value("STATUS", rd, 32'h0);
        apb_read(ADDR_RESULT, rd, err);
        check_value("RESULT", rd, 32'h0);
        for (int k = 0; k < NUM_LANES; k++)
        begin
            w_mdl[k] = '0;
            a_mdl[k] = '0;
        end
        check_operands();
        load_operands(1'b0);
        check_operands();
        apb_write(ADDR_CTRL, 32'h0000_5a00, err);
        apb_read(ADDR_CTRL, rd, err);
        check_value("CTRL", rd, 32'h0000_5a00);
        end_test("readback");

        // all lanes enabled
        load_operands(1'b0);
        run_dot(8'hff);
        end_test("full_mask");

        // single lane and odd counts before random masks
        for (int i = 0; i < 6; i++)
        begin
            rng = xorshift32(rng);
            case (i)
                0: mask = 8'h01;
                1: mask = 8'h80;
                2: mask = 8'h07;
                default: mask = (rng[7:0] == 8'h00) ? 8'h2c : rng[7:0];
            endcase
            load_operands(1'b0);
            run_dot(mask);
        end
        end_test("partial_mask");

        // empty mask then a ctrl write without start
        run_dot(8'h00);
        apb_write(ADDR_CTRL, 32'h0, err);
        apb_read(ADDR_STATUS, rd, err);
        check_value("STATUS", rd, 32'h2);
        end_test("zero_mask");

        load_operands(1'b1);
        run_dot(8'hff);
        end_test("wrap");

        // back to back starts where the second one wins
        load_operands(1'b0);
        apb_write(ADDR_CTRL, 32'h0000_f001, err);
        apb_write(ADDR_CTRL, 32'h0000_3501, err);
        exp_q.push_back(32'(ref_dot(8'h35)));
        wait_done(rd, n_reads);
        // first token lands on the second start edge and keeps done set
        check_value("STATUS reads", 32'(n_reads), 32'd1);
        apb_read(ADDR_RESULT, rd, err);
        obs_q.push_back(rd);
        drain_compare();
        // unmapped addresses flag an error and write nothing
        apb_write(8'h10, 32'hdead_beef, err);
        check_value("PSLVERR", 32'(err), 32'h1);
        apb_write(8'h40, 32'hdead_beef, err);
        check_value("PSLVERR", 32'(err), 32'h1);
        apb_read(8'h0c, rd, err);
        check_value("PSLVERR", 32'(err), 32'h1);
        apb_read(ADDR_CTRL, rd, err);
        check_value("CTRL", rd, 32'h0000_3500);
        check_value("PSLVERR", 32'(err), 32'h0);
        apb_read(ADDR_RESULT, rd, err);
        check_value("RESULT", rd, 32'(ref_dot(8'h35)));
        check_operands();
        end_test("overlap_unmapped");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: project.f
rtl/dot_pkg.sv
rtl/apb_regs.sv
rtl/mult_array.sv
rtl/adder_tree_comb.sv
rtl/result_reg.sv
rtl/dot_engine_top.sv
dv/dot_engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dot_engine_tb
RTL_TOP   ?= dot_engine_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
